//--- a7800_input_top.sv
`timescale 1ns/10ps
`default_nettype none

module a7800_input_top (
	input  wire logic                        clk_sys,
	input  wire logic                        reset,
	input  wire logic                        dl_active,
	input  wire logic                        dl_index_tia,
	input  wire logic [cart_pkg::DL_ADDR_W-1:0] dl_addr,
	input  wire logic [7:0]                  dl_data,
	input  wire logic                        dl_wr,
	input  wire ctrl_pkg::joy_t              joy_a,
	input  wire ctrl_pkg::joy_t              joy_b,
	input  wire logic                        diff_left,
	input  wire logic                        diff_right,
	input  wire logic [1:0]                  override_a,
	input  wire logic [1:0]                  override_b,
	input  wire ctrl_pkg::ps2_key_t          ps2_key,
	input  wire ctrl_pkg::ps2_mouse_t        ps2_mouse,
	input  wire logic [7:0]                  pa_out,
	input  wire logic [7:0]                  pb_out,
	input  wire logic                        pa_read,
	input  wire logic                        tia_en,
	output logic [7:0]                       pa_in,
	output logic [7:0]                       pb_in,
	output logic [1:0]                       ilatch,
	output logic [3:0]                       idump,
	output cart_pkg::cart_info_t             cart_info
);

	logic [2:0] kp_a, kp_b;
	logic [3:0] tb_pulses;
	logic       tb_button;

	download_if dl ();

	assign dl.active    = dl_active;
	assign dl.index_tia = dl_index_tia;
	assign dl.addr      = dl_addr;
	assign dl.data      = dl_data;
	assign dl.wr        = dl_wr;

	cart_header_parser u_parser (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.info    (cart_info)
	);

	// Upper nibble of port A scans the left keypad
	keypad_matrix u_keypad (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ps2_key     (ps2_key),
		.col_drive_a (pa_out[7:4]),
		.col_drive_b (pa_out[3:0]),
		.ans_a       (kp_a),
		.ans_b       (kp_b)
	);

	trackball_feeder u_trackball (
		.clk_sys (clk_sys),
		.reset   (reset),
		.mouse   (ps2_mouse),
		.pa_read (pa_read),
		.pulses  (tb_pulses),
		.button  (tb_button)
	);

	controller_port_mux u_mux (
		.info       (cart_info),
		.override_a (override_a),
		.override_b (override_b),
		.joy_a      (joy_a),
		.joy_b      (joy_b),
		.diff_left  (diff_left),
		.diff_right (diff_right),
		.pa_out     (pa_out),
		.pb_out     (pb_out),
		.tia_en     (tia_en),
		.kp_a       (kp_a),
		.kp_b       (kp_b),
		.tb_pulses  (tb_pulses),
		.tb_button  (tb_button),
		.pa_in      (pa_in),
		.pb_in      (pb_in),
		.ilatch     (ilatch),
		.idump      (idump),
		.port_a     (),
		.port_b     ()
	);

endmodule

`default_nettype wire

//--- cart_header_parser.sv
`timescale 1ns/10ps
`default_nettype none

module cart_header_parser (
	input  wire logic           clk_sys,
	input  wire logic           reset,
	download_if.sink            dl,
	output cart_pkg::cart_info_t info
);
	import cart_pkg::*;

	logic [39:0] sig;           // Signature shift register
	logic        past_header;   // A byte beyond the header came in this download

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			info         <= '0;
			info.is_7800 <= 1'b1;
			info.size    <= 32'd32768;
			sig          <= CART_SIG;
			past_header  <= 1'b0;
		end else begin
			info.is_7800 <= (sig == CART_SIG);
			past_header  <= dl.active & (past_header | (dl.wr & (dl.addr >= HDR_LEN)));

			// Running size, header stripped for 7800 images
			if (dl.active && dl.wr)
				info.size <= 32'(dl.addr) + 32'd1 - (info.is_7800 ? 32'(HDR_LEN) : 32'd0);

			if (dl.active) begin
				info.tia_mode <= dl.index_tia;
				if (!info.tia_mode) begin
					if (dl.wr) begin
						case (dl.addr) inside
							[HDR_SIG_FIRST:HDR_SIG_LAST]: sig <= {sig[31:0], dl.data};
							HDR_FLAGS_HI: info.flags[15:8] <= dl.data;
							HDR_FLAGS_LO: info.flags[7:0]  <= dl.data;
							HDR_JOY0:     info.joy0_code   <= hdr_ctrl_e'(dl.data);
							HDR_JOY1:     info.joy1_code   <= hdr_ctrl_e'(dl.data);
							HDR_REGION:   info.region      <= dl.data;
							HDR_SAVE:     info.save        <= dl.data;
							HDR_XM:       info.xm          <= dl.data;
							default: ;
						endcase
					end
				end else begin
					// 2600 image has no header at all
					sig            <= '0;
					info.flags     <= '0;
					info.region    <= '0;
					info.save      <= '0;
					info.xm        <= '0;
					info.joy0_code <= HC_JOY7800;
					info.joy1_code <= HC_JOY7800;
				end
			end
		end
	end

	// Addresses rise through a download, so the size can only grow once
	// the header is behind us
	assert property (@(posedge clk_sys) disable iff (reset)
		dl.active && dl.wr && past_header |=> info.size >= $past(info.size))
	else
		$error("cartridge size went down in the middle of a download");

endmodule

`default_nettype wire

//--- cart_pkg.sv
`default_nettype none

package cart_pkg;

	// Byte offsets inside the 128-byte A78 header
	localparam int HDR_SIG_FIRST = 1;   // "ATARI" starts here
	localparam int HDR_SIG_LAST  = 5;
	localparam int HDR_FLAGS_HI  = 53;
	localparam int HDR_FLAGS_LO  = 54;
	localparam int HDR_JOY0      = 55;
	localparam int HDR_JOY1      = 56;
	localparam int HDR_REGION    = 57;  // 0 ntsc, 1 pal
	localparam int HDR_SAVE      = 58;  // 0 none, 1 hsc, 2 savekey
	localparam int HDR_XM        = 63;
	localparam int HDR_LEN       = 128;

	localparam logic [39:0] CART_SIG = 40'h41_54_41_52_49;

	// Download address width of the loader
	localparam int DL_ADDR_W = 25;

	// Controller codes as written in the header
	typedef enum logic [7:0] {
		HC_NONE       = 8'd0,
		HC_JOY7800    = 8'd1,
		HC_LIGHTGUN   = 8'd2,
		HC_PADDLE     = 8'd3,
		HC_TRAKBALL   = 8'd4,
		HC_JOY2600    = 8'd5,
		HC_DRIVING    = 8'd6,
		HC_KEYPAD     = 8'd7,
		HC_STMOUSE    = 8'd8,
		HC_AMIGAMOUSE = 8'd9
	} hdr_ctrl_e;

	typedef struct packed {
		logic        is_7800;
		logic [15:0] flags;
		logic [7:0]  region;
		logic [7:0]  save;
		logic [7:0]  xm;
		hdr_ctrl_e   joy0_code;
		hdr_ctrl_e   joy1_code;
		logic [31:0] size;       // Payload bytes without header
		logic        tia_mode;   // 2600 image
	} cart_info_t;

endpackage

`default_nettype wire

//--- controller_port_mux.sv
`timescale 1ns/10ps
`default_nettype none

module controller_port_mux (
	input  wire cart_pkg::cart_info_t info,
	input  wire logic [1:0]           override_a,
	input  wire logic [1:0]           override_b,
	input  wire ctrl_pkg::joy_t       joy_a,
	input  wire ctrl_pkg::joy_t       joy_b,
	input  wire logic                 diff_left,
	input  wire logic                 diff_right,
	input  wire logic [7:0]           pa_out,
	input  wire logic [7:0]           pb_out,
	input  wire logic                 tia_en,
	input  wire logic [2:0]           kp_a,
	input  wire logic [2:0]           kp_b,
	input  wire logic [3:0]           tb_pulses,
	input  wire logic                 tb_button,
	output logic [7:0]                pa_in,
	output logic [7:0]                pb_in,
	output logic [1:0]                ilatch,
	output logic [3:0]                idump,
	output ctrl_pkg::port_in_t        port_a,
	output ctrl_pkg::port_in_t        port_b
);
	import cart_pkg::*;
	import ctrl_pkg::*;

	hdr_ctrl_e  code_a, code_b;
	ctrl_kind_e kind_a, kind_b, kind_b_raw;
	logic       two_btn_a, two_btn_b;

	function automatic ctrl_kind_e resolve_kind(input logic [1:0] ovr, input hdr_ctrl_e code);
		ctrl_kind_e kind;
		if (ovr != 2'd0) begin
			kind = ctrl_kind_e'(ovr - 2'd1);
		end else begin
			case (code)
				HC_JOY7800, HC_JOY2600: kind = CTRL_JOYSTICK;
				HC_TRAKBALL:            kind = CTRL_TRACKBALL;
				HC_KEYPAD:              kind = CTRL_KEYPAD;
				default:                kind = CTRL_NONE;
			endcase
		end
		return kind;
	endfunction

	function automatic port_in_t build_port(
		input ctrl_kind_e kind,
		input joy_t       joy,
		input logic [3:0] drive,
		input logic [2:0] kp,
		input logic [3:0] pulses,
		input logic       button,
		input logic       two_btn
	);
		port_in_t p;
		case (kind)
			CTRL_JOYSTICK: begin
				p.pa     = ~{joy.right, joy.left, joy.down, joy.up};
				p.ilatch = ~(joy.fire1 | joy.fire2);
				p.idump  = {joy.fire1, joy.fire2};
			end
			CTRL_TRACKBALL: begin
				p.pa     = pulses;
				p.ilatch = ~button;
				p.idump  = 2'b00;
			end
			CTRL_KEYPAD: begin
				p.pa     = drive;   // Rows read back what the CPU drives
				p.ilatch = kp[2];
				p.idump  = kp[1:0];
			end
			default: begin
				p.pa     = 4'b1111;
				p.ilatch = 1'b1;
				p.idump  = 2'b00;
			end
		endcase
		// Strong pull-up on pin 6 in two-button mode
		if (two_btn)
			p.ilatch = 1'b1;
		return p;
	endfunction

	// Non-7800 images always get plain joysticks
	assign code_a = info.is_7800 ? info.joy0_code : HC_JOY7800;
	assign code_b = info.is_7800 ? info.joy1_code : HC_JOY7800;

	assign kind_a     = resolve_kind(override_a, code_a);
	assign kind_b_raw = resolve_kind(override_b, code_b);
	// Only one trackball feed, port A has it first
	assign kind_b = (kind_b_raw == CTRL_TRACKBALL && kind_a == CTRL_TRACKBALL) ?
		CTRL_JOYSTICK : kind_b_raw;

	assign two_btn_a = ~pb_out[2] & ~tia_en & (code_a != HC_JOY2600);
	assign two_btn_b = ~pb_out[4] & ~tia_en & (code_b != HC_JOY2600);

	assign port_a = build_port(kind_a, joy_a, pa_out[7:4], kp_a, tb_pulses, tb_button, two_btn_a);
	assign port_b = build_port(kind_b, joy_b, pa_out[3:0], kp_b, tb_pulses, tb_button, two_btn_b);

	assign pa_in  = {port_a.pa, port_b.pa};
	assign ilatch = {port_b.ilatch, port_a.ilatch};
	assign idump  = {port_b.idump, port_a.idump};

	assign pb_in = {
		~diff_right,
		~diff_left,
		pb_out[5],
		pb_out[4],                      // Two-button sense
		~(joy_a.pause | joy_b.pause),
		pb_out[2],
		~(joy_a.select | joy_b.select),
		~(joy_a.start | joy_b.start)
	};

endmodule

`default_nettype wire

//--- ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	typedef enum logic [1:0] {
		CTRL_NONE      = 2'd0,
		CTRL_JOYSTICK  = 2'd1,
		CTRL_TRACKBALL = 2'd2,
		CTRL_KEYPAD    = 2'd3
	} ctrl_kind_e;

	// Up sits at bit 0, start at bit 8
	typedef struct packed {
		logic start;
		logic select;
		logic pause;
		logic fire2;
		logic fire1;
		logic right;
		logic left;
		logic down;
		logic up;
	} joy_t;

	// What one controller port hands to the RIOT and TIA
	typedef struct packed {
		logic [3:0] pa;
		logic       ilatch;
		logic [1:0] idump;
	} port_in_t;

	// PS/2 set 2 codes, number row first
	localparam logic [8:0] KEY_1     = 9'h016;
	localparam logic [8:0] KEY_2     = 9'h01E;
	localparam logic [8:0] KEY_3     = 9'h026;
	localparam logic [8:0] KEY_4     = 9'h025;
	localparam logic [8:0] KEY_5     = 9'h02E;
	localparam logic [8:0] KEY_6     = 9'h036;
	localparam logic [8:0] KEY_7     = 9'h03D;
	localparam logic [8:0] KEY_8     = 9'h03E;
	localparam logic [8:0] KEY_9     = 9'h046;
	localparam logic [8:0] KEY_0     = 9'h045;
	localparam logic [8:0] KEY_MINUS = 9'h04E;
	localparam logic [8:0] KEY_EQUAL = 9'h055;
	localparam logic [8:0] KEY_Q     = 9'h015;  // Letter block layout
	localparam logic [8:0] KEY_W     = 9'h01D;
	localparam logic [8:0] KEY_E     = 9'h024;
	localparam logic [8:0] KEY_A     = 9'h01C;
	localparam logic [8:0] KEY_S     = 9'h01B;
	localparam logic [8:0] KEY_D     = 9'h023;
	localparam logic [8:0] KEY_Z     = 9'h01A;
	localparam logic [8:0] KEY_X     = 9'h022;
	localparam logic [8:0] KEY_C     = 9'h021;

	// Held flag index of each matrix spot, row * 3 + column - 1
	localparam int KEY_ROW1 = 0;   // 1 2 3
	localparam int KEY_ROW2 = 3;   // 4 5 6
	localparam int KEY_ROW3 = 6;   // 7 8 9
	localparam int KEY_STAR = 9;
	localparam int KEY_ZERO = 10;
	localparam int KEY_HASH = 11;

	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	typedef struct packed {
		logic       toggle;
		logic [7:0] y;
		logic [7:0] x;
		logic [1:0] ovf;      // Overflow, not used here
		logic       sign_y;
		logic       sign_x;
		logic       one;      // Always set by the mouse
		logic [2:0] buttons;  // Middle, right, left
	} ps2_mouse_t;

endpackage

`default_nettype wire

//--- download_if.sv
`timescale 1ns/10ps
`default_nettype none

interface download_if;
	import cart_pkg::*;

	logic                 active;
	logic                 index_tia;  // Upper index bits nonzero
	logic [DL_ADDR_W-1:0] addr;
	logic [7:0]           data;
	logic                 wr;         // One byte per high cycle

	modport source (
		output active,
		output index_tia,
		output addr,
		output data,
		output wr
	);

	modport sink (
		input active,
		input index_tia,
		input addr,
		input data,
		input wr
	);

endinterface

`default_nettype wire

//--- flist.f
cart_pkg.sv
ctrl_pkg.sv
download_if.sv
cart_header_parser.sv
keypad_matrix.sv
trackball_feeder.sv
controller_port_mux.sv
a7800_input_top.sv
tb_a7800_input.sv

//--- input_vectors.txt
# name kind a b c d, fields in hex; hdr: offset count bytes | load: tia last_addr is_7800 size
# set: joy_a joy_b {ovr_a ovr_b tia_en diff_l diff_r} {pa_out pb_out} | key: code pressed row col
cart7800 hdr 1 5 4154415249 0
cart7800 hdr 35 2 a512 0
cart7800 hdr 37 2 0107 0
cart7800 hdr 39 2 0102 0
cart7800 hdr 3f 1 01 0
cart7800 load 0 407f 1 4000
keypad set 000 000 00100 fd34
keypad kpad 1 0 0 0
keypad key 02e 1 1 2
keypad kpad 1 0 0 0
keypad key 01d 0 1 2
keypad kpad 1 0 0 0
trackball set 000 000 30100 fd34
trackball mouse 03 00 0 0
trackball read 5 3 0 0
cart2600 load 1 fff 0 1000
joystick set 018 040 00110 ff34
joystick port 0 3a 0 0
joystick pb b7 0 0 0
joystick set 018 040 00010 ff30
joystick port 0 3e 0 0
joystick pb b3 0 0 0
none_override set 000 000 01100 ff34
none_override jrand 1 03f 0 0
none_override port 1 7c 0 0
none_override jrand 1 03f 0 0
none_override port 1 7c 0 0

//--- keypad_matrix.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_matrix (
	input  wire logic               clk_sys,
	input  wire logic               reset,
	input  wire ctrl_pkg::ps2_key_t ps2_key,
	input  wire logic [3:0]         col_drive_a,
	input  wire logic [3:0]         col_drive_b,
	output logic [2:0]              ans_a,
	output logic [2:0]              ans_b
);
	import ctrl_pkg::*;

	logic [11:0] held;        // Index is row * 3 + column - 1
	logic        toggle_q;
	logic [2:0]  ans_a_next;
	logic [2:0]  ans_b_next;

	always_ff @(posedge clk_sys) begin
		toggle_q <= ps2_key.toggle;
		if (reset) begin
			held <= '0;
		end else if (toggle_q != ps2_key.toggle) begin
			case (ps2_key.code)
				KEY_1:            held[KEY_ROW1]     <= ps2_key.pressed;
				KEY_2:            held[KEY_ROW1 + 1] <= ps2_key.pressed;
				KEY_3:            held[KEY_ROW1 + 2] <= ps2_key.pressed;
				KEY_4, KEY_Q:     held[KEY_ROW2]     <= ps2_key.pressed;
				KEY_5, KEY_W:     held[KEY_ROW2 + 1] <= ps2_key.pressed;
				KEY_6, KEY_E:     held[KEY_ROW2 + 2] <= ps2_key.pressed;
				KEY_7, KEY_A:     held[KEY_ROW3]     <= ps2_key.pressed;
				KEY_8, KEY_S:     held[KEY_ROW3 + 1] <= ps2_key.pressed;
				KEY_9, KEY_D:     held[KEY_ROW3 + 2] <= ps2_key.pressed;
				KEY_EQUAL, KEY_Z: held[KEY_STAR]     <= ps2_key.pressed;
				KEY_0, KEY_X:     held[KEY_ZERO]     <= ps2_key.pressed;
				KEY_MINUS, KEY_C: held[KEY_HASH]     <= ps2_key.pressed;
				default: ;
			endcase
		end
	end

	// Pull-ups unless a held key shorts a column to its row line
	always_comb begin
		ans_a_next = '1;
		ans_b_next = '1;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 3; c++) begin
				if (held[r * 3 + c]) begin
					ans_a_next[c] = col_drive_a[r];
					ans_b_next[c] = col_drive_b[r];
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		ans_a <= ans_a_next;
		ans_b <= ans_b_next;
	end

	// Reset empties the matrix and the answer stage follows one edge later
	assert property (@(posedge clk_sys)
		$fell(reset) |=> (ans_a == 3'b111) && (ans_b == 3'b111))
	else
		$error("keypad answers not idle right after reset");

endmodule

`default_nettype wire

//--- tb_a7800_input.sv
`timescale 1ns/10ps
`default_nettype none

module tb_a7800_input;
	import cart_pkg::*;
	import ctrl_pkg::*;

	logic                 clk_sys;
	logic                 reset;
	logic                 dl_active;
	logic                 dl_index_tia;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [7:0]           dl_data;
	logic                 dl_wr;
	joy_t                 joy_a, joy_b;
	logic                 diff_left, diff_right;
	logic [1:0]           override_a, override_b;
	ps2_key_t             ps2_key;
	ps2_mouse_t           ps2_mouse;
	logic [7:0]           pa_out, pb_out;
	logic                 pa_read;
	logic                 tia_en;
	logic [7:0]           pa_in, pb_in;
	logic [1:0]           ilatch;
	logic [3:0]           idump;
	cart_info_t           cart_info;

	logic [7:0] hdr_mem [0:HDR_LEN-1];  // Header bytes of the next image
	logic       held [0:3][0:2];        // Keypad model, row then column
	logic [7:0] ball_mag_x, ball_mag_y;
	logic       ball_xtog, ball_ytog, ball_dir_x, ball_dir_y, ball_button;

	a7800_input_top DUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_index_tia (dl_index_tia),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.dl_wr        (dl_wr),
		.joy_a        (joy_a),
		.joy_b        (joy_b),
		.diff_left    (diff_left),
		.diff_right   (diff_right),
		.override_a   (override_a),
		.override_b   (override_b),
		.ps2_key      (ps2_key),
		.ps2_mouse    (ps2_mouse),
		.pa_out       (pa_out),
		.pb_out       (pb_out),
		.pa_read      (pa_read),
		.tia_en       (tia_en),
		.pa_in        (pa_in),
		.pb_in        (pb_in),
		.ilatch       (ilatch),
		.idump        (idump),
		.cart_info    (cart_info)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_info(input string name, input cart_info_t exp, input cart_info_t act);
		if (act !== exp)
			report_fail($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_port(input string name, input port_in_t exp, input port_in_t act);
		if (act !== exp)
			report_fail($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_pb(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			report_fail($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			report_fail($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
	endtask

	// Inputs move 1 ns after the rising edge
	task automatic next_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	function automatic logic [7:0] image_byte(input logic [DL_ADDR_W-1:0] addr);
		if (addr < HDR_LEN)
			return hdr_mem[addr[6:0]];
		return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ {7'd0, addr[24]};
	endfunction

	function automatic port_in_t sampled_port(input int port);
		port_in_t p;
		if (port == 0)
			p = {pa_in[7:4], ilatch[0], idump[1:0]};
		else
			p = {pa_in[3:0], ilatch[1], idump[3:2]};
		return p;
	endfunction

	// A held key ties its column line to the driven row
	function automatic port_in_t keypad_port(input int port);
		logic [3:0] drive;
		logic [2:0] ans;
		port_in_t   p;
		drive = (port == 0) ? pa_out[7:4] : pa_out[3:0];
		ans   = 3'b111;
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 3; c++)
				if (held[r][c])
					ans[c] = drive[r];
		p.pa     = drive;
		p.ilatch = ans[2];
		p.idump  = ans[1:0];
		return p;
	endfunction

	task automatic store_header(input int offset, input int count, input logic [63:0] bytes);
		for (int i = 0; i < count; i++)
			hdr_mem[offset + i] = bytes[8 * (count - 1 - i) +: 8];  // First byte leftmost
	endtask

	task automatic load_image(input string name, input logic tia, input int last,
			input logic exp_7800, input logic [31:0] exp_size);
		cart_info_t exp;
		int         addr;
		int         cycles;
		dl_active    = 1'b1;
		dl_index_tia = tia;
		dl_wr        = 1'b0;
		next_cycle();
		for (addr = 0; addr <= last; addr++) begin
			dl_addr = DL_ADDR_W'(addr);
			dl_data = image_byte(DL_ADDR_W'(addr));
			dl_wr   = 1'b1;
			next_cycle();
		end
		dl_wr = 1'b0;
		next_cycle();
		dl_active = 1'b0;
		exp          = '0;
		exp.is_7800  = exp_7800;
		exp.tia_mode = tia;
		exp.size     = exp_size;
		if (tia) begin
			exp.joy0_code = HC_JOY7800;  // 2600 images get plain sticks
			exp.joy1_code = HC_JOY7800;
		end else begin
			exp.flags     = {hdr_mem[HDR_FLAGS_HI], hdr_mem[HDR_FLAGS_LO]};
			exp.joy0_code = hdr_ctrl_e'(hdr_mem[HDR_JOY0]);
			exp.joy1_code = hdr_ctrl_e'(hdr_mem[HDR_JOY1]);
			exp.region    = hdr_mem[HDR_REGION];
			exp.save      = hdr_mem[HDR_SAVE];
			exp.xm        = hdr_mem[HDR_XM];
		end
		for (cycles = 0; cycles < 16; cycles++) begin
			@(negedge clk_sys);
			if (cart_info === exp)
				break;
		end
		if (cycles == 16)
			$display("cartridge info did not settle within 16 cycles after the download");
		check_info(name, exp, cart_info);
		next_cycle();
	endtask

	task automatic apply_inputs(input logic [63:0] ja, jb, ctl, ports);
		joy_a      = joy_t'(ja[8:0]);
		joy_b      = joy_t'(jb[8:0]);
		override_a = ctl[17:16];
		override_b = ctl[13:12];
		tia_en     = ctl[8];
		diff_left  = ctl[4];
		diff_right = ctl[0];
		pa_out     = ports[15:8];
		pb_out     = ports[7:0];
		next_cycle();
	endtask

	task automatic randomize_joystick(input int port, input logic [8:0] mask);
		logic [31:0] r;
		r = $urandom;
		if (port == 0)
			joy_a = joy_t'((joy_a & ~mask) | (r[8:0] & mask));
		else
			joy_b = joy_t'((joy_b & ~mask) | (r[8:0] & mask));
		next_cycle();
	endtask

	task automatic key_event(input logic [8:0] code, input logic pressed, input int row,
			input int col);
		ps2_key.code    = code;
		ps2_key.pressed = pressed;
		ps2_key.toggle  = ~ps2_key.toggle;
		held[row][col - 1] = pressed;
		next_cycle();  // Held flag
		next_cycle();  // Answer stage
	endtask

	task automatic mouse_packet(input logic [7:0] x, y, input logic sx, sy,
			input logic [2:0] buttons);
		ps2_mouse.x       = x;
		ps2_mouse.y       = y;
		ps2_mouse.sign_x  = sx;
		ps2_mouse.sign_y  = sy;
		ps2_mouse.buttons = buttons;
		ps2_mouse.one     = 1'b1;
		ps2_mouse.ovf     = 2'b00;
		ps2_mouse.toggle  = ~ps2_mouse.toggle;
		ball_mag_x  = sx ? ~x : x;  // Negative counts arrive inverted
		ball_mag_y  = sy ? ~y : y;
		ball_dir_x  = ~sx;
		ball_dir_y  = sy;
		ball_button = buttons[0] | buttons[1];
		next_cycle();
	endtask

	task automatic read_trackball(input string name, input int reads, input int exp_x,
			input int exp_y);
		logic [3:0] prev;
		port_in_t   exp;
		int         x_changes;
		int         y_changes;
		x_changes = 0;
		y_changes = 0;
		@(negedge clk_sys);
		prev = pa_in[7:4];
		for (int k = 0; k < reads; k++) begin
			next_cycle();
			pa_read = 1'b1;
			next_cycle();
			pa_read = 1'b0;
			// Registered output carries the toggles from before the step
			exp.pa     = {ball_ytog, ball_dir_y, ball_xtog, ball_dir_x};
			exp.ilatch = ~ball_button;
			exp.idump  = 2'b00;
			if (ball_mag_x != 8'd0) begin
				ball_xtog  = ~ball_xtog;
				ball_mag_x = ball_mag_x - 8'd1;
			end
			if (ball_mag_y != 8'd0) begin
				ball_ytog  = ~ball_ytog;
				ball_mag_y = ball_mag_y - 8'd1;
			end
			@(negedge clk_sys);
			check_port(name, exp, sampled_port(0));
			if (pa_in[5] !== prev[1])
				x_changes++;
			if (pa_in[7] !== prev[3])
				y_changes++;
			prev = pa_in[7:4];
		end
		next_cycle();
		check_count({name, " x toggles"}, exp_x, x_changes);
		check_count({name, " y toggles"}, exp_y, y_changes);
	endtask

	initial begin
		int               fd;
		int               n;
		string            name;
		string            kind;
		logic [63:0]      a, b, c, d;
		logic [8*256-1:0] rest;
		logic [31:0]      seed;
		reset        = 1'b1;
		dl_active    = 1'b0;
		dl_index_tia = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		dl_wr        = 1'b0;
		joy_a        = '0;
		joy_b        = '0;
		diff_left    = 1'b0;
		diff_right   = 1'b0;
		override_a   = 2'd0;
		override_b   = 2'd0;
		ps2_key      = '0;
		ps2_mouse    = '0;
		pa_out       = 8'hff;
		pb_out       = 8'hff;
		pa_read      = 1'b0;
		tia_en       = 1'b1;
		ball_mag_x   = '0;
		ball_mag_y   = '0;
		ball_xtog    = 1'b0;
		ball_ytog    = 1'b0;
		ball_dir_x   = 1'b0;
		ball_dir_y   = 1'b0;
		ball_button  = 1'b0;
		for (int i = 0; i < HDR_LEN; i++)
			hdr_mem[i] = 8'h00;
		for (int r = 0; r < 4; r++)
			for (int k = 0; k < 3; k++)
				held[r][k] = 1'b0;
		seed = $urandom(99);

		repeat (3) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		fd = $fopen("input_vectors.txt", "r");
		if (fd == 0)
			report_fail("could not open input_vectors.txt");
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", name);
			if (n != 1)
				break;
			if (name.substr(0, 0) == "#") begin
				n = $fgets(rest, fd);  // Comment line
				continue;
			end
			n = $fscanf(fd, "%s %h %h %h %h", kind, a, b, c, d);
			if (n != 5)
				report_fail($sformatf("step %s in input_vectors.txt is incomplete", name));
			if (kind == "hdr")
				store_header(int'(a), int'(b), c);
			else if (kind == "load")
				load_image(name, a[0], int'(b), c[0], d[31:0]);
			else if (kind == "set")
				apply_inputs(a, b, c, d);
			else if (kind == "jrand")
				randomize_joystick(int'(a), b[8:0]);
			else if (kind == "key")
				key_event(a[8:0], b[0], int'(c), int'(d));
			else if (kind == "kpad") begin
				@(negedge clk_sys);
				check_port(name, keypad_port(int'(a)), sampled_port(int'(a)));
				next_cycle();
			end else if (kind == "mouse")
				mouse_packet(a[7:0], b[7:0], c[0], c[1], d[2:0]);
			else if (kind == "read")
				read_trackball(name, int'(a), int'(b), int'(c));
			else if (kind == "port") begin
				@(negedge clk_sys);
				check_port(name, port_in_t'(b[6:0]), sampled_port(int'(a)));
				next_cycle();
			end else if (kind == "pb") begin
				@(negedge clk_sys);
				check_pb(name, a[7:0], pb_in);
				next_cycle();
			end else
				report_fail($sformatf("unknown step kind %s in input_vectors.txt", kind));
		end
		$fclose(fd);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- trackball_feeder.sv
`timescale 1ns/10ps
`default_nettype none

module trackball_feeder (
	input  wire logic                 clk_sys,
	input  wire logic                 reset,
	input  wire ctrl_pkg::ps2_mouse_t mouse,
	input  wire logic                 pa_read,
	output logic [3:0]                pulses,
	output logic                      button
);
	import ctrl_pkg::*;

	logic [7:0] mag_x, mag_y;   // Steps still to send
	logic       dir_x, dir_y;
	logic       xtog, ytog;
	logic       toggle_q;

	always_ff @(posedge clk_sys) begin
		toggle_q <= mouse.toggle;
		if (reset) begin
			mag_x  <= '0;
			mag_y  <= '0;
			xtog   <= 1'b0;
			ytog   <= 1'b0;
			dir_x  <= 1'b0;
			dir_y  <= 1'b0;
			pulses <= '0;
			button <= 1'b0;
		end else begin
			// One step per RIOT port A read
			if (pa_read) begin
				if (mag_y != 8'd0) begin
					ytog  <= ~ytog;
					mag_y <= mag_y - 8'd1;
				end
				if (mag_x != 8'd0) begin
					xtog  <= ~xtog;
					mag_x <= mag_x - 8'd1;
				end
				pulses <= {ytog, dir_y, xtog, dir_x};
			end

			// A new packet replaces whatever is left
			if (toggle_q != mouse.toggle) begin
				button <= mouse.buttons[0] | mouse.buttons[1];
				mag_x  <= mouse.sign_x ? ~mouse.x : mouse.x;
				mag_y  <= mouse.sign_y ? ~mouse.y : mouse.y;
				dir_x  <= ~mouse.sign_x;   // X runs the other way on this ball
				dir_y  <= mouse.sign_y;
			end
		end
	end

endmodule

`default_nettype wire
